/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ret_predict_tb
FILELIST  = ret_predict.f
OBJ_DIR   = obj_dir
LOG       = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/instr_predecode.sv */
// combinational pre-decoder; is_jump_o flags every jal (direct target known), funct3 of jalr not checked
`timescale 1ns/1ps

module instr_predecode import ret_predict_pkg::*; (
  // instruction at the current fetch address
  input  instr_t instr_i,
  // fetch address of that instruction
  input  addr_t  pc_i,
  // writes a link register
  output logic   is_call_o,
  // reads a link register as target, swap included
  output logic   is_ret_o,
  // jal, so the target is pc plus immediate
  output logic   is_jump_o,
  // pc plus J-immediate
  output addr_t  jump_target_o,
  // address of the following instruction
  output addr_t  link_addr_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       op_jal;
  logic       op_jalr;
  logic       rd_link;
  logic       rs1_link;
  addr_t      j_imm;

  // fixed field positions of the base ISA
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // classify by opcode only
  assign op_jal  = (opcode == OPC_JAL);
  assign op_jalr = (opcode == OPC_JALR);

  // x1 and x5 are both treated as link registers
  assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
  assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

  // J-immediate: imm[20|10:1|11|19:12], sign extended, bit 0 always zero
  assign j_imm = {{12{instr_i[31]}},
                  instr_i[19:12],
                  instr_i[20],
                  instr_i[30:21],
                  1'b0};

  always_comb begin
    // any jump that writes a link register is a call
    is_call_o = (op_jal || op_jalr) && rd_link;
    // return when rd is not a link register
    is_ret_o = op_jalr && rs1_link && !rd_link;
    // swap: both links but different, so pop and push together
    if (op_jalr && rs1_link && rd_link && (rd != rs1)) begin
      is_ret_o = 1'b1;
    end
    // jal always has a known target, call or not
    is_jump_o = op_jal;
  end

  // target adders, used only when the kind asks for them
  assign jump_target_o = pc_i + j_imm;
  assign link_addr_o   = pc_i + INSTR_BYTES;

endmodule

/* hdl/next_pc_select.sv */
// fetch PC and prediction registers; redirect beats a same-cycle instruction, jalr calls predict sequential
`timescale 1ns/1ps

module next_pc_select import ret_predict_pkg::*; #(
  parameter addr_t BOOT_ADDR = 32'h0000_1000
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // one-cycle strobe meaning the instruction at pc_o is present
  input  logic  instr_valid_i,
  // one-cycle strobe from the back end
  input  logic  redirect_i,
  input  addr_t redirect_pc_i,
  // classification from the pre-decoder
  input  logic  is_call_i,
  input  logic  is_ret_i,
  input  logic  is_jump_i,
  input  addr_t jump_target_i,
  input  addr_t link_addr_i,
  // current top of the stack
  input  addr_t ras_top_i,
  input  logic  ras_top_valid_i,
  // stack operations
  output logic  ras_push_o,
  output logic  ras_pop_o,
  output logic  ras_flush_o,
  output addr_t pc_o,
  output addr_t pred_target_o,
  output kind_t pred_kind_o,
  output logic  pred_taken_o,
  output logic  pred_valid_o
);

  logic  accept;
  addr_t target;
  kind_t kind;
  logic  taken;
  addr_t pc_q;

  // instruction counts only without a redirect in the same cycle
  assign accept = instr_valid_i && !redirect_i;

  assign ras_push_o  = accept && is_call_i;
  assign ras_pop_o   = accept && is_ret_i;
  assign ras_flush_o = redirect_i;

  always_comb begin
    // fall through to the next instruction
    target = link_addr_i;
    kind   = KIND_SEQ;
    taken  = 1'b0;
    if (is_ret_i) begin
      // return and swap both take the stack top when present
      kind = KIND_RET;
      if (ras_top_valid_i) begin
        target = ras_top_i;
        taken  = 1'b1;
      end
    end else if (is_call_i) begin
      kind = KIND_CALL;
      // jal call has a direct target while a jalr call target is unknown here
      if (is_jump_i) begin
        target = jump_target_i;
        taken  = 1'b1;
      end
    end else if (is_jump_i) begin
      kind   = KIND_JUMP;
      target = jump_target_i;
      taken  = 1'b1;
    end
  end

  // fetch pc and the registered prediction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q          <= BOOT_ADDR;
      pred_valid_o  <= 1'b0;
      pred_target_o <= '0;
      pred_kind_o   <= KIND_SEQ;
      pred_taken_o  <= 1'b0;
    end else begin
      pred_valid_o <= accept;
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (accept) begin
        pc_q          <= target;
        pred_target_o <= target;
        pred_kind_o   <= kind;
        pred_taken_o  <= taken;
      end
    end
  end

  assign pc_o = pc_q;

endmodule

/* hdl/ret_predict_pkg.sv */
// shared types and RV32I constants for the return predictor; only 32-bit encodings, no RVC
package ret_predict_pkg;

  // fetch and return addresses
  typedef logic [31:0] addr_t;
  // raw instruction word as fetched
  typedef logic [31:0] instr_t;
  // prediction kind, plain vector with named values
  typedef logic [1:0] kind_t;

  // sequential, or target not known at fetch
  localparam kind_t KIND_SEQ  = 2'd0;
  // direct jal without link
  localparam kind_t KIND_JUMP = 2'd1;
  // jal or jalr writing a link register
  localparam kind_t KIND_CALL = 2'd2;
  // return, coroutine swap included
  localparam kind_t KIND_RET  = 2'd3;

  // link registers per the RISC-V calling convention hints
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

  // major opcodes of the two jump instructions
  localparam logic [6:0] OPC_JAL  = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // fixed instruction size, no compressed support
  localparam addr_t INSTR_BYTES = 32'd4;

endpackage

/* hdl/ret_predict_top.sv */
// return-prediction front end top; one instruction per strobe, no back-pressure, DEPTH of 2 or more
`timescale 1ns/1ps

module ret_predict_top import ret_predict_pkg::*; #(
  parameter int unsigned DEPTH     = 4,
  parameter addr_t       BOOT_ADDR = 32'h0000_1000
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   instr_valid_i,
  input  instr_t instr_i,
  input  logic   redirect_i,
  input  addr_t  redirect_pc_i,
  output addr_t  pc_o,
  output logic   pred_valid_o,
  output addr_t  pred_target_o,
  output kind_t  pred_kind_o,
  output logic   pred_taken_o
);

  // pre-decoder results
  logic  is_call;
  logic  is_ret;
  logic  is_jump;
  addr_t jump_target;
  addr_t link_addr;
  // stack interface
  logic  ras_push;
  logic  ras_pop;
  logic  ras_flush;
  addr_t ras_top;
  logic  ras_top_valid;

  // decodes the instruction at the current fetch address
  instr_predecode instr_predecode_inst (
    .instr_i       (instr_i),
    .pc_i          (pc_o),
    .is_call_o     (is_call),
    .is_ret_o      (is_ret),
    .is_jump_o     (is_jump),
    .jump_target_o (jump_target),
    .link_addr_o   (link_addr)
  );

  // pushed value is always the link address of the call
  return_addr_stack #(
    .DEPTH (DEPTH)
  ) return_addr_stack_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (ras_flush),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .data_i      (link_addr),
    .top_o       (ras_top),
    .top_valid_o (ras_top_valid)
  );

  next_pc_select #(
    .BOOT_ADDR (BOOT_ADDR)
  ) next_pc_select_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid_i),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .is_call_i       (is_call),
    .is_ret_i        (is_ret),
    .is_jump_i       (is_jump),
    .jump_target_i   (jump_target),
    .link_addr_i     (link_addr),
    .ras_top_i       (ras_top),
    .ras_top_valid_i (ras_top_valid),
    .ras_push_o      (ras_push),
    .ras_pop_o       (ras_pop),
    .ras_flush_o     (ras_flush),
    .pc_o            (pc_o),
    .pred_target_o   (pred_target_o),
    .pred_kind_o     (pred_kind_o),
    .pred_taken_o    (pred_taken_o),
    .pred_valid_o    (pred_valid_o)
  );

endmodule

/* hdl/return_addr_stack.sv */
// shift-register return-address stack, DEPTH must be 2 or more; overflow drops the oldest entry
`timescale 1ns/1ps

module return_addr_stack import ret_predict_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // clear all entries, wins over push and pop
  input  logic  flush_i,
  input  logic  push_i,
  input  logic  pop_i,
  // link address to push
  input  addr_t data_i,
  // entry 0 is the top of the stack
  output addr_t top_o,
  output logic  top_valid_o
);

  addr_t addr_d [DEPTH];
  addr_t addr_q [DEPTH];
  logic  [DEPTH-1:0] valid_d;
  logic  [DEPTH-1:0] valid_q;

  assign top_o       = addr_q[0];
  assign top_valid_o = valid_q[0];

  always_comb begin
    // hold by default
    addr_d  = addr_q;
    valid_d = valid_q;
    if (flush_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        addr_d[i] = '0;
      end
      valid_d = '0;
    end else if (push_i && pop_i) begin
      // swap, the return consumes the top and the call refills it
      addr_d[0]  = data_i;
      valid_d[0] = 1'b1;
    end else if (push_i) begin
      // shift down, bottom entry falls off when full
      for (int i = DEPTH - 1; i > 0; i--) begin
        addr_d[i]  = addr_q[i-1];
        valid_d[i] = valid_q[i-1];
      end
      addr_d[0]  = data_i;
      valid_d[0] = 1'b1;
    end else if (pop_i) begin
      // shift up and free the bottom slot
      for (int i = 0; i < DEPTH - 1; i++) begin
        addr_d[i]  = addr_q[i+1];
        valid_d[i] = valid_q[i+1];
      end
      addr_d[DEPTH-1]  = '0;
      valid_d[DEPTH-1] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        addr_q[i] <= '0;
      end
      valid_q <= '0;
    end else begin
      addr_q  <= addr_d;
      valid_q <= valid_d;
    end
  end

endmodule

/* ret_predict.f */
hdl/ret_predict_pkg.sv
hdl/instr_predecode.sv
hdl/return_addr_stack.sv
hdl/next_pc_select.sv
hdl/ret_predict_top.sv
test/clk_rst_gen.sv
test/ret_predict_sva.sv
test/ret_predict_tb.sv

/* test/clk_rst_gen.sv */
// testbench clock and power-on reset; reset is released on a falling edge after RESET_CYCLES
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // active-low reset, held for a whole number of cycles
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* test/ret_predict_sva.sv */
// assertions bound into ret_predict_top; assumes the source never strobes two cycles in a row
`timescale 1ns/1ps

module ret_predict_sva import ret_predict_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  redirect_i,
  input addr_t redirect_pc_i,
  input addr_t pc_o,
  input logic  pred_valid_o,
  input logic  pred_taken_o,
  input kind_t pred_kind_o
);

  // one prediction per strobe, so never two in a row
  assert property (@(posedge clk_i) disable iff (!rst_ni) pred_valid_o |=> !pred_valid_o)
    else $error("pred_valid_o high for two cycles in a row");

  // nothing predicted straight out of reset
  assert property (@(posedge clk_i) $rose(rst_ni) |-> !pred_valid_o)
    else $error("pred_valid_o high right after reset");

  // redirect address shows up on pc_o one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    redirect_i |=> (pc_o == $past(redirect_pc_i)))
    else $error("pc_o did not follow the redirect address");

  // a sequential prediction is never taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pred_valid_o |-> !(pred_taken_o && (pred_kind_o == KIND_SEQ)))
    else $error("taken prediction reported with KIND_SEQ");

endmodule

bind ret_predict_top ret_predict_sva ret_predict_sva_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .redirect_i    (redirect_i),
  .redirect_pc_i (redirect_pc_i),
  .pc_o          (pc_o),
  .pred_valid_o  (pred_valid_o),
  .pred_taken_o  (pred_taken_o),
  .pred_kind_o   (pred_kind_o)
);

/* test/ret_predict_tb.sv */
// directed tests for ret_predict_top with DEPTH 4; expected values come from a reference stack
`timescale 1ns/1ps

module ret_predict_tb import ret_predict_pkg::*; ();

  localparam int unsigned DEPTH     = 4;
  localparam addr_t       BOOT_ADDR = 32'h0000_1000;
  localparam int          TIMEOUT   = 50;

  logic   clk;
  logic   rst_n;
  logic   instr_valid;
  logic   redirect;
  logic   pred_valid;
  logic   pred_taken;
  instr_t instr;
  addr_t  redirect_pc;
  addr_t  pc;
  addr_t  pred_target;
  kind_t  pred_kind;

  integer seed = 32'hb72cf8c6;
  int     errors;
  int     checks;
  int     tests;
  int     start_errors;
  // name of the running test for report lines
  string  cur;
  // expected fetch pc and reference stack with entry 0 on top
  addr_t  exp_pc;
  addr_t  ref_addr [DEPTH];
  logic   ref_valid [DEPTH];

  clk_rst_gen clk_rst_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  ret_predict_top #(.DEPTH(DEPTH), .BOOT_ADDR(BOOT_ADDR)) ret_predict_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .pc_o          (pc),
    .pred_valid_o  (pred_valid),
    .pred_target_o (pred_target),
    .pred_kind_o   (pred_kind),
    .pred_taken_o  (pred_taken)
  );

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", cur, what, exp, act);
    end
  endtask

  task automatic check_kind(input kind_t exp, input kind_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s kind: expected %0d, actual %0d", cur, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s %s: expected %b, actual %b", cur, what, exp, act);
    end
  endtask

  // encoders for jal with a J-type offset and jalr with zero offset
  function automatic instr_t enc_jal(input logic [4:0] rd, input addr_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic instr_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h000, rs1, 3'b000, rd, OPC_JALR};
  endfunction

  // even offset in the signed 21-bit jal range
  function automatic addr_t rand_off();
    addr_t r;
    r = $random(seed);
    return {{11{r[20]}}, r[20:1], 1'b0};
  endfunction

  // random word forced onto the OP-IMM opcode so it is never a jump
  function automatic instr_t rand_plain();
    instr_t r;
    r = $random(seed);
    return {r[31:7], 7'b0010011};
  endfunction

  // x1 and x5 act as link registers
  function automatic logic is_link(input logic [4:0] r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  task automatic clear_ref();
    for (int i = 0; i < DEPTH; i++) begin
      ref_addr[i]  = '0;
      ref_valid[i] = 1'b0;
    end
  endtask

  // strobe one instruction, update the model, wait for the prediction and check it
  task automatic issue(input instr_t w, input addr_t off);
    logic  jal;
    logic  jalr;
    logic  call;
    logic  ret;
    logic  tk;
    kind_t k;
    addr_t t;
    addr_t link;
    int    n;
    jal  = (w[6:0] == OPC_JAL);
    jalr = (w[6:0] == OPC_JALR);
    // any link write is a call
    call = (jal || jalr) && is_link(w[11:7]);
    // jalr through a link is a return unless rd repeats the same link
    ret  = jalr && is_link(w[19:15]) && !(is_link(w[11:7]) && w[11:7] == w[19:15]);
    link = exp_pc + 32'd4;
    t    = link;
    k    = KIND_SEQ;
    tk   = 1'b0;
    if (ret) begin
      k = KIND_RET;
      if (ref_valid[0]) begin
        t  = ref_addr[0];
        tk = 1'b1;
      end
    end else if (call) begin
      k = KIND_CALL;
      if (jal) begin
        t  = exp_pc + off;
        tk = 1'b1;
      end
    end else if (jal) begin
      k  = KIND_JUMP;
      t  = exp_pc + off;
      tk = 1'b1;
    end
    // reference stack where a swap overwrites the top, a push shifts down and a pop shifts up
    if (call && ret) begin
      ref_addr[0]  = link;
      ref_valid[0] = 1'b1;
    end else if (call) begin
      for (int i = DEPTH - 1; i > 0; i--) begin
        ref_addr[i]  = ref_addr[i-1];
        ref_valid[i] = ref_valid[i-1];
      end
      ref_addr[0]  = link;
      ref_valid[0] = 1'b1;
    end else if (ret) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        ref_addr[i]  = ref_addr[i+1];
        ref_valid[i] = ref_valid[i+1];
      end
      ref_valid[DEPTH-1] = 1'b0;
    end
    exp_pc = t;
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = w;
    @(negedge clk);
    instr_valid = 1'b0;
    n = 0;
    while (!pred_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!pred_valid) begin
      errors++;
      $display("%s: no prediction arrived within %0d cycles", cur, TIMEOUT);
    end else begin
      check_addr("target", t, pred_target);
      check_kind(k, pred_kind);
      check_bit("taken", tk, pred_taken);
      check_addr("pc", t, pc);
    end
  endtask

  // redirect with a competing call in the same cycle that must be ignored
  task automatic do_redirect(input addr_t a);
    int n;
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = a;
    instr_valid = 1'b1;
    instr       = enc_jal(5'd1, 32'd16);
    @(negedge clk);
    redirect    = 1'b0;
    instr_valid = 1'b0;
    n = 0;
    while (pc !== a && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (pc !== a) begin
      errors++;
      $display("%s: pc_o never took the redirect address", cur);
    end
    check_bit("pred_valid", 1'b0, pred_valid);
    exp_pc = a;
    clear_ref();
  endtask

  task automatic begin_test(input string name);
    cur          = name;
    start_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == start_errors) begin
      $display("%s: ok", cur);
    end else begin
      $display("%s: %0d errors", cur, errors - start_errors);
    end
  endtask

  task automatic reset_values();
    int n;
    begin_test("reset");
    n = 0;
    // rst_n may still be unknown at time zero
    while (rst_n !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("%s: reset was never released", cur);
    end
    @(negedge clk);
    check_addr("pc", BOOT_ADDR, pc);
    // quiet window before the first strobe
    repeat (4) begin
      @(negedge clk);
      check_bit("pred_valid", 1'b0, pred_valid);
    end
    end_test();
  endtask

  task automatic seq_and_jump();
    addr_t off;
    begin_test("seq_and_jump");
    issue(rand_plain(), '0);
    off = rand_off();
    issue(enc_jal(5'd0, off), off);
    issue(rand_plain(), '0);
    end_test();
  endtask

  // calls by jal on x1 followed by returns through x1
  task automatic calls_then_returns(input int calls, input int rets);
    addr_t off;
    for (int i = 0; i < calls; i++) begin
      off = rand_off();
      issue(enc_jal(5'd1, off), off);
    end
    for (int i = 0; i < rets; i++) begin
      issue(enc_jalr(5'd0, 5'd1), '0);
    end
  endtask

  task automatic nested_calls();
    begin_test("nested_calls");
    calls_then_returns(3, 3);
    end_test();
  endtask

  // two more calls than entries, so the fifth return finds an empty stack
  task automatic overflow_drop();
    begin_test("stack_overflow");
    calls_then_returns(6, 5);
    end_test();
  endtask

  task automatic redirect_flush();
    begin_test("redirect_flush");
    calls_then_returns(2, 0);
    do_redirect({$random(seed)} & 32'hffff_fffc);
    issue(enc_jalr(5'd0, 5'd1), '0);
    end_test();
  endtask

  // jalr x1 through x5 pops the caller and pushes its own link
  task automatic coroutine_swap();
    begin_test("coroutine_swap");
    calls_then_returns(1, 0);
    issue(enc_jalr(5'd1, 5'd5), '0);
    issue(enc_jalr(5'd0, 5'd1), '0);
    issue(enc_jalr(5'd0, 5'd1), '0);
    end_test();
  endtask

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    exp_pc      = BOOT_ADDR;
    clear_ref();
    reset_values();
    seq_and_jump();
    nested_calls();
    overflow_drop();
    redirect_flush();
    coroutine_swap();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
